// ==== vlog.f ====
+incdir+include
src/obj_pkg.sv
src/obj_bus_pkg.sv
src/obj_line_scan.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_engine.sv
test/obj_rom_model.sv
test/obj_engine_tb.sv

// ==== Makefile ====
# Verilator build and run of the object engine testbench.

SRCS := $(shell grep -v '^+' vlog.f) include/obj_config.svh

run: obj_dir/Vobj_engine_tb
	obj_dir/Vobj_engine_tb > sim.log
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

# rebuilt only when a source or the file list changes.
obj_dir/Vobj_engine_tb: vlog.f $(SRCS)
	verilator --binary --timing -f vlog.f --top-module obj_engine_tb -o Vobj_engine_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== test/obj_engine_tb.sv ====
/*
 * object engine testbench.
 * random object lists against a line model, x window, hflip and
 * clear-on-read checks, cycle limit and final status.
 */

`timescale 1ns/1ps

`include "obj_config.svh"

module obj_engine_tb import obj_pkg::*, obj_bus_pkg::*; ();

    localparam int N_RAND  = 8;
    localparam int N_LINES = 17;   // read passes over the whole run.
    localparam int MAX_CYC = N_LINES * (`OBJ_LIST_MAX * 40 + 600);
    localparam lbuf_pix_t CLEAR = 9'h1ff;

    logic         clk = 1'b0;
    logic         rst;
    logic         obj_wr;
    obj_entry_t   obj_wdata;
    logic         line_start;
    logic         busy;
    logic [8:0]   rd_addr;
    lbuf_pix_t    rd_pix;
    obj_rom_req_t rom_req;
    logic [31:0]  rom_data;
    logic         rom_ok;

    int         seed = 32'h7ed5d037;
    int         cycles = 0;
    int         errors = 0;
    int         test_err = 0;
    int         tests = 0;
    int         failed = 0;
    lbuf_pix_t  exp_line [512];    // expected content of the drawn half.
    obj_entry_t objs [$];          // list of the next line.

    always #2 clk = ~clk;

    obj_engine uut (
        .clk(clk), .rst(rst), .obj_wr(obj_wr), .obj_wdata(obj_wdata),
        .line_start(line_start), .busy(busy), .rd_addr(rd_addr), .rd_pix(rd_pix),
        .rom_req(rom_req), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    obj_rom_model #(.SEED(32'h7ed5d037)) u_rom (
        .clk(clk), .rst(rst), .rom_req(rom_req), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYC) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYC);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and model.
    task automatic check_pix(input string sig, input lbuf_pix_t got, input lbuf_pix_t exp);
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("** Error at %0t: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("** Error at %0t: busy = %b, expected %b", $time, got, exp);
        end
    endtask

    // ROM select must be released once the drawer is done.
    task automatic check_rom_cs(input obj_rom_req_t got, input logic exp);
        if (got.cs !== exp) begin
            errors++;
            test_err++;
            $display("** Error at %0t: rom_req.cs = %b, expected %b", $time, got.cs, exp);
        end
    endtask

    function automatic obj_entry_t rand_obj();
        obj_entry_t e;
        e.code = 16'($random(seed));
        e.attr = 16'($random(seed));
        e.hpos = 9'($random(seed));
        e.bank = 2'($random(seed));
        return e;
    endfunction

    task automatic apply_obj(input obj_entry_t e);
        logic [31:0] d;
        logic [3:0]  c;
        logic [8:0]  x;
        if (e.hpos > `OBJ_XMIN && e.hpos < `OBJ_XMAX) begin
            x = e.hpos;
            for (int w = 0; w < 2; w++) begin
                d = u_rom.rom_word(e.bank, {e.code, e.attr.vsub}, e.attr.hflip ^ w[0]);
                for (int k = 0; k < 8; k++) begin
                    c = e.attr.hflip ? {d[24+k], d[16+k], d[8+k], d[k]}
                                     : {d[31-k], d[23-k], d[15-k], d[7-k]};
                    if (!(&d) && c != `OBJ_TRANSP) begin
                        exp_line[x] = '{pal: e.attr.pal, colour: c};
                    end
                    x = x + 9'd1;   // blank words still move x by 8.
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus tasks.
    task automatic read_pass(input logic check_it);
        for (int a = 0; a <= 512; a++) begin
            @(posedge clk);
            rd_addr <= (a < 512) ? 9'(a) : 9'd0;   // park at 0, never drawn.
            @(negedge clk);
            if (check_it && a > 0) begin
                check_pix($sformatf("rd_pix[%0d]", a - 1), rd_pix, exp_line[a-1]);
            end
        end
    endtask

    task automatic next_line();
        @(posedge clk);
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        @(negedge clk);
        check_busy(busy, 1'b1);
        while (busy) @(negedge clk);
        check_rom_cs(rom_req, 1'b0);
    endtask

    // load, draw, swap with an empty list, then compare the shown half.
    task automatic run_line();
        foreach (exp_line[i]) exp_line[i] = CLEAR;
        foreach (objs[i]) begin
            @(posedge clk);
            obj_wr    <= 1'b1;
            obj_wdata <= objs[i];
            apply_obj(objs[i]);
        end
        @(posedge clk);
        obj_wr <= 1'b0;
        next_line();
        next_line();
        read_pass(1'b1);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_err != 0) failed++;
        $display("test %-8s %s, %0d errors", name, (test_err != 0) ? "failed" : "ok", test_err);
        test_err = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence.
    initial begin
        int         n;
        obj_entry_t e;
        rst        = 1'b1;
        obj_wr     = 1'b0;
        obj_wdata  = '0;
        line_start = 1'b0;
        rd_addr    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_busy(busy, 1'b0);
        check_rom_cs(rom_req, 1'b0);
        read_pass(1'b0);   // clears half 1.
        next_line();
        read_pass(1'b0);   // clears half 0.
        next_line();
        foreach (exp_line[i]) exp_line[i] = CLEAR;
        read_pass(1'b1);
        check_busy(busy, 1'b0);
        end_test("reset");

        for (int l = 0; l < N_RAND; l++) begin
            n = 1 + $unsigned($random(seed)) % `OBJ_LIST_MAX;
            objs.delete();
            repeat (n) objs.push_back(rand_obj());
            run_line();
        end
        end_test("random");

        objs.delete();
        for (int i = 0; i < 8; i++) begin
            e = rand_obj();
            e.hpos = i[0] ? 9'h1c0 + 9'(i * 8 - 8) : 9'h30 - 9'(i * 4);
            objs.push_back(e);
        end
        run_line();
        objs.delete();
        run_line();
        end_test("window");

        // code with two opaque words, drawn plain and mirrored.
        e = rand_obj();
        e.hpos = 9'h80;
        while (&u_rom.rom_word(e.bank, {e.code, e.attr.vsub}, 1'b0) ||
               &u_rom.rom_word(e.bank, {e.code, e.attr.vsub}, 1'b1)) e.code++;
        for (int f = 0; f < 2; f++) begin
            e.attr.hflip = f[0];
            objs.delete();
            objs.push_back(e);
            run_line();
        end
        end_test("hflip");

        objs.delete();
        repeat (16) objs.push_back(rand_obj());
        run_line();
        foreach (exp_line[i]) exp_line[i] = CLEAR;
        read_pass(1'b1);
        end_test("clear");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/obj_rom_model.sv ====
/*
 * graphics ROM model.
 * random 1 to 4 cycle latency per request, data from a fixed hash of
 * bank, address and half, about one word in four blank.
 */

`timescale 1ns/1ps

module obj_rom_model import obj_bus_pkg::*; #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic         clk,
    input  logic         rst,
    input  obj_rom_req_t rom_req,
    output logic [31:0]  rom_data,
    output logic         rom_ok
);

    int           seed = SEED;
    obj_rom_req_t last_req;
    logic [2:0]   delay;

    // word content of one tile row half.
    function automatic logic [31:0] rom_word(input logic [1:0] bank, input logic [19:0] addr,
                                             input logic half);
        logic [31:0] h;
        h = {9'h0, bank, half, addr} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return (h[31:30] == 2'b00) ? 32'hffff_ffff : h;   // forced blank.
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            last_req <= '0;
            delay    <= '0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else begin
            last_req <= rom_req;
            if (rom_req != last_req) begin
                rom_ok <= 1'b0;   // new request, old data no longer valid.
                delay  <= 3'd1 + 3'($unsigned($random(seed)) % 32'd4);
            end else if (delay != 3'd0) begin
                delay <= delay - 3'd1;
                if (delay == 3'd1 && rom_req.cs) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_word(rom_req.bank, rom_req.addr, rom_req.half);
                end
            end
        end
    end

endmodule

// ==== src/obj_engine.sv ====
/*
 * object line engine top.
 * list scanner, object drawer and double line buffer.
 */

`timescale 1ns/1ps

module obj_engine import obj_pkg::*, obj_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // host side.
    input  logic         obj_wr,
    input  obj_entry_t   obj_wdata,
    input  logic         line_start,
    output logic         busy,

    // display side.
    input  logic [8:0]   rd_addr,
    output lbuf_pix_t    rd_pix,

    // graphics ROM.
    output obj_rom_req_t rom_req,
    input  logic [31:0]  rom_data,
    input  logic         rom_ok
);

    obj_entry_t cur_obj;
    logic       draw_start;
    logic       draw_idle;
    lbuf_wr_t   lbuf_wr;

    obj_line_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .obj_wr     (obj_wr),
        .obj_wdata  (obj_wdata),
        .line_start (line_start),
        .busy       (busy),
        .obj        (cur_obj),
        .start      (draw_start),
        .idle       (draw_idle)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .obj        (cur_obj),
        .start      (draw_start),
        .idle       (draw_idle),
        .lbuf_wr    (lbuf_wr),
        .rom_req    (rom_req),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

    obj_line_buf u_lbuf (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .lbuf_wr    (lbuf_wr),
        .rd_addr    (rd_addr),
        .rd_pix     (rd_pix)
    );

endmodule

// ==== src/obj_line_buf.sv ====
/*
 * double line buffer.
 * one half is drawn while the other is displayed and cleared behind
 * the read pointer. transparent writes are dropped.
 */

`timescale 1ns/1ps

`include "obj_config.svh"

module obj_line_buf import obj_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       line_start,
    input  lbuf_wr_t   lbuf_wr,

    input  logic [8:0] rd_addr,
    output lbuf_pix_t  rd_pix
);

    localparam lbuf_pix_t CLEAR_PIX = '{pal: 5'h1f, colour: `OBJ_TRANSP};

    logic            bank;       // half being drawn.
    logic            wr_ok;
    lbuf_pix_t [1:0] rd_half;

    assign wr_ok = lbuf_wr.we && lbuf_wr.pix.colour != `OBJ_TRANSP;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (line_start) begin
            bank <= ~bank;   // swap draw and display.
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // the two halves, identical apart from their bank select.
    for (genvar h = 0; h < 2; h++) begin : g_half
        lbuf_pix_t mem [512];

        always_ff @(posedge clk) begin
            if (bank == 1'(h)) begin
                if (wr_ok) begin
                    mem[lbuf_wr.addr] <= lbuf_wr.pix;
                end
            end else begin
                mem[rd_addr] <= CLEAR_PIX;   // cleared as it is shown.
            end
        end

        assign rd_half[h] = mem[rd_addr];
    end

    // display read, one cycle latency.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pix <= CLEAR_PIX;
        end else begin
            rd_pix <= rd_half[~bank];
        end
    end

endmodule

// ==== src/obj_draw.sv ====
/*
 * object drawer.
 * fetches the two words of one tile row, converts planar data to
 * pixels and writes them to the line buffer.
 */

`timescale 1ns/1ps

`include "obj_config.svh"

module obj_draw import obj_pkg::*, obj_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    input  obj_entry_t   obj,
    input  logic         start,
    output logic         idle,

    output lbuf_wr_t     lbuf_wr,

    output obj_rom_req_t rom_req,
    input  logic [31:0]  rom_data,
    input  logic         rom_ok
);

    logic [31:0] pxl_data;     // shifts one pixel per write.
    logic [8:0]  x_pos;
    logic [4:0]  pal_q;
    logic        hflip_q;
    logic        second;       // working on the second word.
    logic        draw;
    logic [2:0]  draw_cnt;
    logic [1:0]  wait_sr;      // holds off rom_ok after a request change.
    logic        rom_good;
    logic        in_window;

    // planar pixel, msb from the top plane.
    function automatic logic [3:0] plane_pix(input logic [31:0] d, input logic flip);
        return flip ? {d[24], d[16], d[8], d[0]} : {d[31], d[23], d[15], d[7]};
    endfunction

    assign in_window = obj.hpos > `OBJ_XMIN && obj.hpos < `OBJ_XMAX;
    assign rom_good  = rom_ok && wait_sr == 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idle     <= 1'b1;
            rom_req  <= '0;
            lbuf_wr  <= '0;
            pxl_data <= '0;
            x_pos    <= '0;
            pal_q    <= '0;
            hflip_q  <= 1'b0;
            second   <= 1'b0;
            draw     <= 1'b0;
            draw_cnt <= '0;
            wait_sr  <= '0;
        end else begin
            wait_sr    <= wait_sr >> 1;
            lbuf_wr.we <= 1'b0;

            if (idle) begin
                // out of window objects are ignored, idle stays high.
                if (start && in_window) begin
                    idle         <= 1'b0;
                    rom_req.cs   <= 1'b1;
                    rom_req.addr <= {obj.code, obj.attr.vsub};
                    rom_req.bank <= obj.bank;
                    rom_req.half <= obj.attr.hflip;   // mirrored rows start with the other half.
                    wait_sr      <= 2'b11;
                    x_pos        <= obj.hpos;
                    pal_q        <= obj.attr.pal;
                    hflip_q      <= obj.attr.hflip;
                    second       <= 1'b0;
                    draw         <= 1'b0;
                end
            end else if (draw) begin
                lbuf_wr.we         <= 1'b1;
                lbuf_wr.addr       <= x_pos;
                lbuf_wr.pix.pal    <= pal_q;
                lbuf_wr.pix.colour <= plane_pix(pxl_data, hflip_q);
                x_pos              <= x_pos + 9'd1;
                pxl_data <= hflip_q ? {1'b1, pxl_data[31:1]} : {pxl_data[30:0], 1'b1};
                draw_cnt           <= draw_cnt + 3'd1;
                if (draw_cnt == 3'd7) begin   // eighth pixel of the word.
                    draw <= 1'b0;
                    if (second) begin
                        idle <= 1'b1;
                    end else begin
                        second <= 1'b1;
                    end
                end
            end else if (rom_good) begin
                pxl_data <= rom_data;
                if (!second) begin
                    rom_req.half <= ~rom_req.half;   // prefetch the other half.
                    wait_sr      <= 2'b11;
                end else begin
                    rom_req.cs <= 1'b0;
                end

                if (&rom_data) begin
                    // blank word, nothing to write.
                    x_pos <= x_pos + 9'd8;
                    if (second) begin
                        idle <= 1'b1;
                    end else begin
                        second <= 1'b1;
                    end
                end else begin
                    draw     <= 1'b1;
                    draw_cnt <= 3'd0;
                end
            end
        end
    end

endmodule

// ==== src/obj_line_scan.sv ====
/*
 * object list storage and scanner.
 * entries are appended by the host, then handed to the drawer one
 * at a time after line_start.
 */

`timescale 1ns/1ps

`include "obj_config.svh"

module obj_line_scan import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       obj_wr,
    input  obj_entry_t obj_wdata,

    input  logic       line_start,
    output logic       busy,

    output obj_entry_t obj,
    output logic       start,
    input  logic       idle
);

    localparam int AW = $clog2(`OBJ_LIST_MAX);
    localparam int CW = $clog2(`OBJ_LIST_MAX + 1);

    obj_entry_t  list [`OBJ_LIST_MAX];
    logic [CW-1:0] wr_cnt;
    logic [CW-1:0] line_cnt;   // entries in the line being scanned.
    logic [CW-1:0] idx;
    scan_state_e state;

    assign obj = list[idx[AW-1:0]];   // stable until idx moves on.

    ////////////////////////////////////////////////////////////////////////
    // list storage.
    always_ff @(posedge clk) begin
        if (obj_wr && wr_cnt != CW'(`OBJ_LIST_MAX)) begin
            list[wr_cnt[AW-1:0]] <= obj_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_cnt <= '0;
        end else if (line_start) begin
            wr_cnt <= '0;   // list handed over to the scan.
        end else if (obj_wr && wr_cnt != CW'(`OBJ_LIST_MAX)) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // scanner.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SCAN_IDLE;
            busy     <= 1'b0;
            start    <= 1'b0;
            idx      <= '0;
            line_cnt <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (line_start) begin
                        line_cnt <= wr_cnt;
                        idx      <= '0;
                        busy     <= 1'b1;
                        state    <= SCAN_ISSUE;
                    end
                end
                SCAN_ISSUE: begin
                    if (idx == line_cnt) begin
                        busy  <= 1'b0;   // last object finished.
                        state <= SCAN_IDLE;
                    end else if (idle) begin
                        start <= 1'b1;
                        state <= SCAN_SETTLE;
                    end
                end
                // drawer idle is not valid yet in this cycle.
                SCAN_SETTLE: state <= SCAN_WAIT;
                SCAN_WAIT: begin
                    if (idle) begin
                        idx   <= idx + 1'b1;
                        state <= SCAN_ISSUE;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

endmodule

// ==== src/obj_bus_pkg.sv ====
/*
 * memory side types.
 * graphics ROM request and line buffer pixel / write.
 */

package obj_bus_pkg;

    // graphics ROM request, one 32-bit half of a tile row.
    typedef struct packed {
        logic        cs;
        logic [1:0]  bank;
        logic        half;
        logic [19:0] addr;     // code, then row.
    } obj_rom_req_t;

    // palette tagged pixel.
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] colour;
    } lbuf_pix_t;

    // single pixel write into the line buffer.
    typedef struct packed {
        logic      we;
        logic [8:0] addr;
        lbuf_pix_t pix;
    } lbuf_wr_t;

endpackage

// ==== src/obj_pkg.sv ====
/*
 * object description types.
 * attribute word, list entry and scanner states.
 */

package obj_pkg;

    // attribute word as held in the object table.
    typedef struct packed {
        logic [3:0] unused;     // high bits, not decoded.
        logic [3:0] vsub;       // tile row.
        logic       rsvd;
        logic       vflip;      // applied by the list builder.
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    // one entry of the per line object list.
    typedef struct packed {
        logic [15:0] code;
        obj_attr_t   attr;
        logic [8:0]  hpos;
        logic [1:0]  bank;
    } obj_entry_t;

    // list scanner states.
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_ISSUE,
        SCAN_SETTLE,
        SCAN_WAIT
    } scan_state_e;

endpackage

// ==== include/obj_config.svh ====
/*
 * object engine build constants.
 * visible x window, list depth and transparent colour.
 */

`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// x window. objects must sit strictly between these.
`define OBJ_XMIN     9'h30
`define OBJ_XMAX     9'h1c0

////////////////////////////////////////////////////////////////////////////
// per line object list.
`define OBJ_LIST_MAX 32

// colour index never written to the line buffer.
`define OBJ_TRANSP   4'hf

`endif
